// ==== files.f ====
+incdir+src
src/tluh_pkg.sv
src/tluh_atomic_alu.sv
src/tluh_host_adapter.sv
src/tluh_mem_device.sv
src/tluh_subsystem_top.sv
testbench/tluh_subsystem_assertions.sv
testbench/tluh_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the tl-uh subsystem testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tluh_subsystem_tb -f files.f

output="$(./obj_dir/Vtluh_subsystem_tb)"
echo "$output"

# the run passes only if the testbench printed its pass line
grep -qx "Done: no errors" <<< "$output"

// ==== src/tluh_atomic_alu.sv ====
// tluh atomic alu: new word for arithmetic and logical atomics, merged with the old word by mask
`timescale 1ns/1ps
`include "tluh_settings.svh"

module tluh_atomic_alu
    import tluh_pkg::*;
(
    input  tluh_a_op_e            opcode_i,
    input  tluh_a_param_u         param_i,
    input  logic [`TLUH_DBW-1:0]  mask_i,
    input  logic [`TLUH_DW-1:0]   old_i,
    input  logic [`TLUH_DW-1:0]   operand_i,
    output logic [`TLUH_DW-1:0]   result_o
);

    logic [`TLUH_DW-1:0] new_word;
    logic                lt_signed;
    logic                lt_unsigned;

    // comparisons are over the whole word, not per lane
    assign lt_signed   = $signed(old_i) < $signed(operand_i);
    assign lt_unsigned = old_i < operand_i;

    always_comb begin
        // unknown codes leave the word as it was
        new_word = old_i;
        case (opcode_i)
            ArithmeticData: begin
                case (param_i.arith)
                    MIN:     new_word = lt_signed ? old_i : operand_i;
                    MAX:     new_word = lt_signed ? operand_i : old_i;
                    MINU:    new_word = lt_unsigned ? old_i : operand_i;
                    MAXU:    new_word = lt_unsigned ? operand_i : old_i;
                    ADD:     new_word = old_i + operand_i;
                    default: new_word = old_i;
                endcase
            end
            LogicalData: begin
                case (param_i.logical)
                    XOR:     new_word = old_i ^ operand_i;
                    OR:      new_word = old_i | operand_i;
                    AND:     new_word = old_i & operand_i;
                    SWAP:    new_word = operand_i;
                    default: new_word = old_i;
                endcase
            end
            default: new_word = old_i;
        endcase
    end

    // lanes outside the mask keep their old bytes
    always_comb begin
        for (int b = 0; b < `TLUH_DBW; b++) begin
            result_o[8*b +: 8] = mask_i[b] ? new_word[8*b +: 8] : old_i[8*b +: 8];
        end
    end

endmodule

// ==== src/tluh_host_adapter.sv ====
// tluh host adapter: turns a host req/gnt/valid port into tl-uh channel A requests and D results
`timescale 1ns/1ps
`include "tluh_settings.svh"

module tluh_host_adapter
    import tluh_pkg::*;
#(
    parameter int unsigned MAX_REQS = `TLUH_MAX_REQS
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [`TLUH_AW-1:0]   addr_i,
    input  logic [`TLUH_DW-1:0]   wdata_i,
    input  logic [`TLUH_DBW-1:0]  be_i,
    input  logic [2:0]            operation_i,
    input  logic                  arithmetic_i,
    input  tluh_d2h_t             tl_d_i,
    output logic                  gnt_o,
    output logic                  valid_o,
    output logic [`TLUH_DW-1:0]   rdata_o,
    output logic                  err_o,
    output tluh_h2d_t             tl_a_o
);

    localparam int unsigned WordOff = $clog2(`TLUH_DBW);
    localparam int unsigned SrcW    = `TLUH_AIW;

    logic [SrcW-1:0]       source;
    tluh_a_op_e            opcode;
    tluh_a_param_u         param;
    logic [`TLUH_DBW-1:0]  mask;

    // opcode choice, first match wins
    // arithmetic codes map straight from operation_i, so MIN is operation 0
    // logical and intent codes are operation_i minus one since zero means a plain access
    always_comb begin
        param = '0;
        if (arithmetic_i) begin
            opcode      = ArithmeticData;
            param.arith = tluh_a_param_arith_e'(operation_i);
        end else if (operation_i != 3'd0 && we_i) begin
            opcode        = LogicalData;
            param.logical = tluh_a_param_log_e'(operation_i - 3'd1);
        end else if (operation_i != 3'd0) begin
            opcode       = Intent;
            param.intent = tluh_a_param_intent_e'(operation_i - 3'd1);
        end else if (!we_i) begin
            opcode = Get;
        end else if (&be_i) begin
            opcode = PutFullData;
        end else begin
            opcode = PutPartialData;
        end
    end

    // reads and hints touch the whole word, every lane enabled
    assign mask = (opcode == Get || opcode == Intent) ? {`TLUH_DBW{1'b1}} : be_i;

    // a single outstanding request never needs a distinct source id
    if (MAX_REQS == 1) begin : g_src_fixed
        assign source = '0;
    end else begin : g_src_count
        localparam int unsigned CntW = $clog2(MAX_REQS);
        logic [CntW-1:0] cnt_q;

        // rotate through the ids, one step per accepted request
        always_ff @(posedge clk_i) begin
            if (!rst_ni) begin
                cnt_q <= '0;
            end else if (req_i && gnt_o) begin
                cnt_q <= (cnt_q == CntW'(MAX_REQS - 1)) ? '0 : cnt_q + 1'b1;
            end
        end

        assign source = SrcW'(cnt_q);
    end

    assign tl_a_o = '{
        a_valid:   req_i,
        a_opcode:  opcode,
        a_param:   param,
        a_size:    `TLUH_SZW'(WordOff),
        a_mask:    mask,
        a_source:  source,
        a_address: {addr_i[`TLUH_AW-1:WordOff], {WordOff{1'b0}}},
        a_data:    wdata_i,
        d_ready:   1'b1
    };

    // responses pass straight through since the host is always ready
    assign gnt_o   = tl_d_i.a_ready;
    assign valid_o = tl_d_i.d_valid;
    assign rdata_o = tl_d_i.d_data;
    assign err_o   = tl_d_i.d_error;

endmodule

// ==== src/tluh_mem_device.sv ====
// tluh memory device: single-port word memory serving tl-uh gets, puts, atomics and intents
`timescale 1ns/1ps
`include "tluh_settings.svh"

module tluh_mem_device
    import tluh_pkg::*;
#(
    parameter int unsigned MEM_WORDS = `TLUH_MEM_WORDS
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  tluh_h2d_t  tl_a_i,
    output tluh_d2h_t  tl_d_o
);

    localparam int unsigned IdxW    = $clog2(MEM_WORDS);
    localparam int unsigned WordOff = $clog2(`TLUH_DBW);
    localparam int unsigned WaW     = `TLUH_AW - WordOff;

    logic [`TLUH_DW-1:0]   mem_q [MEM_WORDS];
    logic [WaW-1:0]        word_addr;
    logic [IdxW-1:0]       idx;
    logic                  in_range, accept, is_atomic, is_put;
    logic [`TLUH_DW-1:0]   put_word, alu_result;
    logic                  rdy_q, pend_q, pend_err_q;
    logic [IdxW-1:0]       pend_idx_q;
    logic [`TLUH_DBW-1:0]  pend_mask_q;
    logic [`TLUH_DW-1:0]   pend_operand_q;
    tluh_a_op_e            pend_op_q;
    tluh_a_param_u         pend_param_q;
    logic                  rsp_valid_q, rsp_err_q;
    tluh_d_op_e            rsp_op_q;
    logic [`TLUH_SZW-1:0]  rsp_size_q;
    logic [`TLUH_AIW-1:0]  rsp_source_q;
    logic [`TLUH_DW-1:0]   rsp_data_q;

    // the range check uses the full word address, so aliases above the memory are errors
    assign word_addr = tl_a_i.a_address[`TLUH_AW-1:WordOff];
    assign in_range  = word_addr < WaW'(MEM_WORDS);
    assign idx       = word_addr[IdxW-1:0];
    assign accept    = tl_a_i.a_valid && rdy_q;
    assign is_atomic = tl_a_i.a_opcode inside {ArithmeticData, LogicalData};
    assign is_put    = tl_a_i.a_opcode inside {PutFullData, PutPartialData};

    always_comb begin
        for (int b = 0; b < `TLUH_DBW; b++) begin
            put_word[8*b +: 8] = tl_a_i.a_mask[b] ? tl_a_i.a_data[8*b +: 8] : mem_q[idx][8*b +: 8];
        end
    end

    // old word comes from the stored index, nothing can write it in between
    tluh_atomic_alu alu0 (
        .opcode_i  (pend_op_q),
        .param_i   (pend_param_q),
        .mask_i    (pend_mask_q),
        .old_i     (mem_q[pend_idx_q]),
        .operand_i (pend_operand_q),
        .result_o  (alu_result)
    );

    // ready drops for the single write cycle that follows an accepted atomic
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rdy_q       <= 1'b0;
            pend_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            rdy_q       <= !(accept && is_atomic);
            pend_q      <= accept && is_atomic;
            rsp_valid_q <= (accept && !is_atomic) || pend_q;
            rsp_err_q   <= (accept && !is_atomic && !in_range) || (pend_q && pend_err_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pend_err_q     <= !in_range;
            pend_idx_q     <= idx;
            pend_mask_q    <= tl_a_i.a_mask;
            pend_operand_q <= tl_a_i.a_data;
            pend_op_q      <= tl_a_i.a_opcode;
            pend_param_q   <= tl_a_i.a_param;
            rsp_source_q   <= tl_a_i.a_source;
            rsp_size_q     <= tl_a_i.a_size;
            rsp_op_q       <= (tl_a_i.a_opcode == Get || is_atomic) ? AccessAckData : AccessAck;
            // atomics load their data one cycle later, in the write cycle
            if (!is_atomic) begin
                rsp_data_q <= (tl_a_i.a_opcode == Get && in_range) ? mem_q[idx] : '0;
            end
            if (is_put && in_range) begin
                mem_q[idx] <= put_word;
            end
        end
        if (pend_q) begin
            rsp_data_q <= pend_err_q ? '0 : mem_q[pend_idx_q];
            if (!pend_err_q) begin
                mem_q[pend_idx_q] <= alu_result;
            end
        end
    end

    // d_ready is not looked at since the host never stalls channel D
    assign tl_d_o = '{
        d_valid:  rsp_valid_q,
        d_opcode: rsp_op_q,
        d_size:   rsp_size_q,
        d_source: rsp_source_q,
        d_data:   rsp_data_q,
        d_error:  rsp_err_q,
        a_ready:  rdy_q
    };

endmodule

// ==== src/tluh_pkg.sv ====
// tluh package: tl-uh opcodes, param codes and the channel A/D structs
`include "tluh_settings.svh"

package tluh_pkg;

    // channel A opcodes with their tl-uh encodings
    typedef enum logic [2:0] {
        PutFullData    = 3'd0,
        PutPartialData = 3'd1,
        ArithmeticData = 3'd2,
        LogicalData    = 3'd3,
        Get            = 3'd4,
        Intent         = 3'd5
    } tluh_a_op_e;

    // channel D opcodes, only the uncached acks are needed
    typedef enum logic [2:0] {
        AccessAck     = 3'd0,
        AccessAckData = 3'd1
    } tluh_d_op_e;

    typedef enum logic [2:0] {
        MIN  = 3'd0,
        MAX  = 3'd1,
        MINU = 3'd2,
        MAXU = 3'd3,
        ADD  = 3'd4
    } tluh_a_param_arith_e;

    typedef enum logic [2:0] {
        XOR  = 3'd0,
        OR   = 3'd1,
        AND  = 3'd2,
        SWAP = 3'd3
    } tluh_a_param_log_e;

    typedef enum logic [2:0] {
        PrefetchRead  = 3'd0,
        PrefetchWrite = 3'd1
    } tluh_a_param_intent_e;

    // the same three param bits mean different things depending on a_opcode
    typedef union packed {
        tluh_a_param_arith_e  arith;
        tluh_a_param_log_e    logical;
        tluh_a_param_intent_e intent;
    } tluh_a_param_u;

    // host to device, channel A plus the D ready
    typedef struct packed {
        logic                  a_valid;
        tluh_a_op_e            a_opcode;
        tluh_a_param_u         a_param;
        logic [`TLUH_SZW-1:0]  a_size;
        logic [`TLUH_DBW-1:0]  a_mask;
        logic [`TLUH_AIW-1:0]  a_source;
        logic [`TLUH_AW-1:0]   a_address;
        logic [`TLUH_DW-1:0]   a_data;
        logic                  d_ready;
    } tluh_h2d_t;

    // device to host, channel D plus the A ready
    typedef struct packed {
        logic                  d_valid;
        tluh_d_op_e            d_opcode;
        logic [`TLUH_SZW-1:0]  d_size;
        logic [`TLUH_AIW-1:0]  d_source;
        logic [`TLUH_DW-1:0]   d_data;
        logic                  d_error;
        logic                  a_ready;
    } tluh_d2h_t;

endpackage

// ==== src/tluh_settings.svh ====
// tluh settings: bus widths, memory depth and outstanding request limit for the tl-uh fabric
`ifndef TLUH_SETTINGS_SVH
`define TLUH_SETTINGS_SVH

// address and data widths of channel A and D
`define TLUH_AW 32
`define TLUH_DW 32

// one mask bit per byte lane of the data word
`define TLUH_DBW (`TLUH_DW / 8)

// source id and size field widths
`define TLUH_AIW 4
`define TLUH_SZW 3

// number of words held by the memory device
`define TLUH_MEM_WORDS 64

// default number of responses the host may keep outstanding
`define TLUH_MAX_REQS 4

`endif

// ==== src/tluh_subsystem_top.sv ====
// tluh subsystem top: host adapter driving one tl-uh memory device
`timescale 1ns/1ps
`include "tluh_settings.svh"

module tluh_subsystem_top
    import tluh_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [`TLUH_AW-1:0]   addr_i,
    input  logic [`TLUH_DW-1:0]   wdata_i,
    input  logic [`TLUH_DBW-1:0]  be_i,
    input  logic [2:0]            operation_i,
    input  logic                  arithmetic_i,
    output logic                  gnt_o,
    output logic                  valid_o,
    output logic [`TLUH_DW-1:0]   rdata_o,
    output logic                  err_o
);

    // channel A towards the device and channel D back
    tluh_h2d_t tl_a;
    tluh_d2h_t tl_d;

    tluh_host_adapter adapter0 (
        .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .operation_i, .arithmetic_i,
        .tl_d_i (tl_d),
        .gnt_o, .valid_o, .rdata_o, .err_o,
        .tl_a_o (tl_a)
    );

    tluh_mem_device mem0 (.clk_i, .rst_ni, .tl_a_i (tl_a), .tl_d_o (tl_d));

endmodule

// ==== testbench/tluh_subsystem_assertions.sv ====
// tluh subsystem assertions: reset quiet, error flag, atomic grant gap and get latency
`timescale 1ns/1ps

module tluh_subsystem_assertions (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        req_i,
    input logic        we_i,
    input logic [2:0]  operation_i,
    input logic        arithmetic_i,
    input logic        gnt_o,
    input logic        valid_o,
    input logic        err_o
);

    // high when the previous edge also saw reset, so the reset edge itself has settled the flops
    logic prev_rst_q = 1'b0;
    logic atomic_acc;
    logic get_acc;

    always @(posedge clk_i) begin
        prev_rst_q <= !rst_ni;
    end

    // same opcode choice as the host port defines it
    assign atomic_acc = req_i && gnt_o && (arithmetic_i || (operation_i != 3'd0 && we_i));
    assign get_acc    = req_i && gnt_o && !arithmetic_i && operation_i == 3'd0 && !we_i;

    reset_quiet: assert property (@(posedge clk_i) !rst_ni && prev_rst_q |-> !gnt_o && !valid_o)
        else $error("gnt_o or valid_o high during reset");

    err_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) err_o |-> valid_o)
        else $error("err_o high without valid_o");

    // the device's write cycle takes exactly one cycle of a_ready
    atomic_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        atomic_acc |=> !gnt_o ##1 gnt_o)
        else $error("gnt_o did not drop for exactly one cycle after an atomic");

    get_latency: assert property (@(posedge clk_i) disable iff (!rst_ni) get_acc |=> valid_o)
        else $error("get response did not arrive one cycle after acceptance");

endmodule

bind tluh_subsystem_top tluh_subsystem_assertions asserts0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .operation_i  (operation_i),
    .arithmetic_i (arithmetic_i),
    .gnt_o        (gnt_o),
    .valid_o      (valid_o),
    .err_o        (err_o)
);

// ==== testbench/tluh_subsystem_tb.sv ====
// tluh subsystem testbench: directed tl-uh traffic checked against a reference word memory
`timescale 1ns/1ps
`include "tluh_settings.svh"

module tluh_subsystem_tb;

    localparam logic [`TLUH_DBW-1:0] AllLanes = '1;
    localparam int unsigned PutRounds = 8;
    localparam int unsigned BurstLen = 6;
    // every task call below issues a known number of requests, the watchdog budgets 10 cycles each
    localparam int unsigned NumReqs = `TLUH_MEM_WORDS + 4 * PutRounds + 2 * 5 + 2 * 4 + 2 * 2
                                      + 2 + BurstLen;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  req_i;
    logic                  we_i;
    logic [`TLUH_AW-1:0]   addr_i;
    logic [`TLUH_DW-1:0]   wdata_i;
    logic [`TLUH_DBW-1:0]  be_i;
    logic [2:0]            operation_i;
    logic                  arithmetic_i;
    logic                  gnt_o;
    logic                  valid_o;
    logic [`TLUH_DW-1:0]   rdata_o;
    logic                  err_o;

    int data_errs = 0;
    int flag_errs = 0;
    int lat_errs = 0;
    int proto_errs = 0;

    // reference copy of the device memory, updated by the rules for each opcode
    logic [`TLUH_DW-1:0] ref_mem [`TLUH_MEM_WORDS];

    // response of the most recent request and the grant seen one cycle after it was accepted
    logic [`TLUH_DW-1:0] rsp_data;
    logic                rsp_err;
    logic                gnt_next;
    int                  rsp_lat;

    tluh_subsystem_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    task automatic check_word(input string name, input logic [`TLUH_DW-1:0] got, exp);
        if (got !== exp) begin
            data_errs++;
            $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            flag_errs++;
            $display("FAILED %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, exp);
        if (got != exp) begin
            lat_errs++;
            $display("FAILED %0t %s: got %0d cycles, expected %0d", $time, name, got, exp);
        end
    endtask

    // enabled byte lanes take the new value, all others keep the old one
    function automatic logic [`TLUH_DW-1:0] merge_lanes(input logic [`TLUH_DW-1:0] old_w, new_w,
                                                        input logic [`TLUH_DBW-1:0] be);
        logic [`TLUH_DW-1:0] w;
        w = old_w;
        for (int b = 0; b < `TLUH_DBW; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    // host operation codes: arithmetic 0..4 is min, max, minu, maxu, add
    // and logical 1..4 is xor, or, and, swap
    function automatic logic [`TLUH_DW-1:0] atomic_ref(input logic arith, input logic [2:0] op,
                                                       input logic [`TLUH_DW-1:0] a, b);
        if (arith) begin
            case (op)
                3'd0: return ($signed(a) <= $signed(b)) ? a : b;
                3'd1: return ($signed(a) >= $signed(b)) ? a : b;
                3'd2: return (a <= b) ? a : b;
                3'd3: return (a >= b) ? a : b;
                default: return a + b;
            endcase
        end
        case (op)
            3'd1: return a ^ b;
            3'd2: return a | b;
            3'd3: return a & b;
            default: return b;
        endcase
    endfunction

    // some lanes enabled but never all of them
    function automatic logic [`TLUH_DBW-1:0] partial_mask();
        int unsigned r;
        r = $urandom_range((1 << `TLUH_DBW) - 2, 1);
        return r[`TLUH_DBW-1:0];
    endfunction

    // one request, held until granted, then wait for its response pulse
    // called and returning just after a falling edge
    task automatic send(input logic we, input logic arith, input logic [2:0] op,
                        input int unsigned word, input logic [`TLUH_DW-1:0] wdata,
                        input logic [`TLUH_DBW-1:0] be);
        int waited;
        waited = 0;
        req_i = 1'b1;
        we_i = we;
        arithmetic_i = arith;
        operation_i = op;
        addr_i = word * 4;
        wdata_i = wdata;
        be_i = be;
        while (!gnt_o && waited < 8) begin
            @(negedge clk_i);
            waited++;
        end
        if (!gnt_o) begin
            proto_errs++;
            $display("request to word %0d was never granted", word);
        end
        @(negedge clk_i);
        gnt_next = gnt_o;
        req_i = 1'b0;
        rsp_lat = 1;
        while (!valid_o && rsp_lat < 8) begin
            @(negedge clk_i);
            rsp_lat++;
        end
        if (!valid_o) begin
            proto_errs++;
            $display("no response came back for the request to word %0d", word);
        end
        rsp_data = rdata_o;
        rsp_err = err_o;
    endtask

    task automatic read_check(input int unsigned word);
        send(1'b0, 1'b0, 3'd0, word, '0, AllLanes);
        check_word("rdata_o", rsp_data, ref_mem[word]);
        check_flag("err_o", rsp_err, 1'b0);
        check_flag("gnt_o", gnt_next, 1'b1);
        check_latency("get latency", rsp_lat, 1);
    endtask

    task automatic write_word(input int unsigned word, input logic [`TLUH_DW-1:0] data,
                              input logic [`TLUH_DBW-1:0] be);
        send(1'b1, 1'b0, 3'd0, word, data, be);
        ref_mem[word] = merge_lanes(ref_mem[word], data, be);
        check_flag("err_o", rsp_err, 1'b0);
        check_latency("put latency", rsp_lat, 1);
    endtask

    // an atomic returns the old word and writes back during the cycle gnt_o is low
    task automatic atomic(input logic arith, input logic [2:0] op, input int unsigned word,
                          input logic [`TLUH_DW-1:0] operand, input logic [`TLUH_DBW-1:0] be);
        send(1'b1, arith, op, word, operand, be);
        check_word("rdata_o", rsp_data, ref_mem[word]);
        check_flag("err_o", rsp_err, 1'b0);
        check_flag("gnt_o", gnt_next, 1'b0);
        check_latency("atomic latency", rsp_lat, 2);
        ref_mem[word] = merge_lanes(ref_mem[word], atomic_ref(arith, op, ref_mem[word], operand),
                                    be);
        read_check(word);
    endtask

    task automatic test_puts();
        int unsigned w;
        for (int i = 0; i < PutRounds; i++) begin
            w = $urandom_range(`TLUH_MEM_WORDS - 1, 0);
            write_word(w, $urandom, AllLanes);
            read_check(w);
            write_word(w, $urandom, partial_mask());
            read_check(w);
        end
    endtask

    task automatic test_atomics();
        for (int op = 0; op < 5; op++) begin
            atomic(1'b1, 3'(op), $urandom_range(`TLUH_MEM_WORDS - 1, 0), $urandom, AllLanes);
        end
        for (int op = 1; op < 5; op++) begin
            atomic(1'b0, 3'(op), $urandom_range(`TLUH_MEM_WORDS - 1, 0), $urandom, partial_mask());
        end
    endtask

    // prefetch read and prefetch write hints leave memory untouched
    task automatic test_intent();
        int unsigned w;
        for (int op = 1; op < 3; op++) begin
            w = $urandom_range(`TLUH_MEM_WORDS - 1, 0);
            send(1'b0, 1'b0, 3'(op), w, $urandom, AllLanes);
            check_flag("err_o", rsp_err, 1'b0);
            check_latency("intent latency", rsp_lat, 1);
            read_check(w);
        end
    endtask

    // the write lands one memory size above a valid word and must not alias onto it
    task automatic test_out_of_range();
        int unsigned w;
        w = $urandom_range(`TLUH_MEM_WORDS - 1, 0);
        send(1'b1, 1'b0, 3'd0, w + `TLUH_MEM_WORDS, $urandom, AllLanes);
        check_flag("err_o", rsp_err, 1'b1);
        check_word("rdata_o", rsp_data, '0);
        read_check(w);
    endtask

    // req_i stays high, a new address goes out each cycle and each response follows one cycle later
    task automatic test_back_to_back();
        int unsigned words [BurstLen];
        for (int k = 0; k < BurstLen; k++) begin
            words[k] = $urandom_range(`TLUH_MEM_WORDS - 1, 0);
        end
        req_i = 1'b1;
        we_i = 1'b0;
        arithmetic_i = 1'b0;
        operation_i = 3'd0;
        be_i = AllLanes;
        addr_i = words[0] * 4;
        for (int k = 0; k < BurstLen; k++) begin
            if (!gnt_o) begin
                proto_errs++;
                $display("back-to-back get %0d was not granted in its cycle", k);
            end
            @(negedge clk_i);
            if (!valid_o) begin
                proto_errs++;
                $display("back-to-back get %0d had no response in the following cycle", k);
            end
            check_word("rdata_o", rdata_o, ref_mem[words[k]]);
            if (k < BurstLen - 1) begin
                addr_i = words[k + 1] * 4;
            end else begin
                req_i = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha7b));
        rst_ni = 1'b0;
        req_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        be_i = '0;
        operation_i = 3'd0;
        arithmetic_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // every word gets a known value before any read
        for (int unsigned w = 0; w < `TLUH_MEM_WORDS; w++) begin
            write_word(w, $urandom, AllLanes);
        end
        test_puts();
        test_atomics();
        test_intent();
        test_out_of_range();
        test_back_to_back();

        $display("error counts: data %0d, flags %0d, latency %0d, protocol %0d",
                 data_errs, flag_errs, lat_errs, proto_errs);
        if (data_errs + flag_errs + lat_errs + proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (NumReqs * 10 + 200) @(posedge clk_i);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule
